// File: hash_1612.f
hdl/hash_pkg.sv
hdl/hash_cfg_pkg.sv
hdl/hash_cfg_regs.sv
hdl/hash_crc_stage.sv
hdl/hash_mix_out.sv
hdl/hash_top.sv
sim/hash_checker.sv
sim/hash_tb.sv

// File: hdl/hash_cfg_pkg.sv
// hash configuration definitions
package hash_cfg_pkg;

  // --------------------
  // register map
  // --------------------

  // three registers on a two bit address, address 3 reads as zero
  typedef enum logic [1:0] {
    CFG_CTRL   = 2'd0,
    CFG_SIZE   = 2'd1,
    CFG_STATUS = 2'd2
  } cfg_addr_e;

  // bit positions inside the register words
  localparam int CTRL_BYPASS_BIT   = 0;
  localparam int STATUS_BAD_SZ_BIT = 0;

  // --------------------
  // configuration word
  // --------------------

  // settings that travel with every key through the stage register
  typedef struct packed {
    logic                   bypass;
    hash_pkg::hash_size_t   hash_size;
  } hash_cfg_t;

  // out of reset the engine hashes at full width with bypass off
  localparam hash_cfg_t CFG_RESET = '{
    bypass:    1'b0,
    hash_size: hash_pkg::hash_size_t'(hash_pkg::MAX_HASH_SIZE)
  };

endpackage

// File: hdl/hash_cfg_regs.sv
// hash configuration registers
`timescale 1ns/10ps

module hash_cfg_regs (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     reg_wr,
  input  logic                     reg_rd,
  input  hash_cfg_pkg::cfg_addr_e  reg_addr,
  input  logic [15:0]              reg_wdata,
  output logic [15:0]              reg_rdata,
  output hash_cfg_pkg::hash_cfg_t  cfg
);

  import hash_pkg::*;
  import hash_cfg_pkg::*;

  // --------------------
  // write decode
  // --------------------

  hash_cfg_t cfg_q;
  logic      bad_size_q;
  logic      wr_ctrl;
  logic      wr_size;
  logic      wr_status;
  logic      size_legal;

  assign wr_ctrl   = reg_wr && (reg_addr == CFG_CTRL);
  assign wr_size   = reg_wr && (reg_addr == CFG_SIZE);
  assign wr_status = reg_wr && (reg_addr == CFG_STATUS);

  // the whole write word is checked so that large values cannot alias
  // onto a legal size through the upper bits being dropped
  assign size_legal = (reg_wdata <= MAX_HASH_SIZE);

  // --------------------
  // registers
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q <= CFG_RESET;
    end else begin
      if (wr_ctrl) begin
        cfg_q.bypass <= reg_wdata[CTRL_BYPASS_BIT];
      end
      // a reserved size is refused and the old size stays in force
      if (wr_size && size_legal) begin
        cfg_q.hash_size <= reg_wdata[SIZE_W-1:0];
      end
    end
  end

  // sticky flag for refused size writes
  // any write to the status address clears it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bad_size_q <= 1'b0;
    end else if (wr_status) begin
      bad_size_q <= 1'b0;
    end else if (wr_size && !size_legal) begin
      bad_size_q <= 1'b1;
    end
  end

  assign cfg = cfg_q;

  // --------------------
  // read back
  // --------------------

  // combinational read, zero when no read strobe is present
  always_comb begin
    reg_rdata = '0;
    if (reg_rd) begin
      case (reg_addr)
        CFG_CTRL:   reg_rdata[CTRL_BYPASS_BIT] = cfg_q.bypass;
        CFG_SIZE:   reg_rdata[SIZE_W-1:0] = cfg_q.hash_size;
        CFG_STATUS: reg_rdata[STATUS_BAD_SZ_BIT] = bad_size_q;
        default:    reg_rdata = '0;
      endcase
    end
  end

endmodule

// File: hdl/hash_crc_stage.sv
// hash input and crc stage
`timescale 1ns/10ps

module hash_crc_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     key_valid,
  input  hash_pkg::key_t           key,
  input  logic                     hold,
  input  hash_cfg_pkg::hash_cfg_t  cfg,
  output hash_pkg::stage_t         stage
);

  import hash_pkg::*;
  import hash_cfg_pkg::*;

  // --------------------
  // crc
  // --------------------

  crc_t crc;

  // each crc bit is the xor of the key bits picked by its tap mask
  always_comb begin
    for (int i = 0; i < CRC_W; i++) begin
      crc[i] = ^(key & CRC_TAPS[i]);
    end
  end

  // --------------------
  // stage register
  // --------------------

  logic      valid_q;
  key_t      key_q;
  crc_t      crc_q;
  hash_cfg_t cfg_q;

  // control and key are cleared by reset
  // while hold is high a new key is ignored and the stage keeps its item
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      key_q   <= '0;
    end else if (!hold) begin
      valid_q <= key_valid;
      key_q   <= key;
    end
  end

  // crc and config are qualified by valid_q
  // the config is sampled in the same edge as its key, so a later
  // register write cannot change a key already in the stage
  always_ff @(posedge clk) begin
    if (!hold) begin
      crc_q <= crc;
      cfg_q <= cfg;
    end
  end

  assign stage.valid = valid_q;
  assign stage.key   = key_q;
  assign stage.crc   = crc_q;
  assign stage.cfg   = cfg_q;

endmodule

// File: hdl/hash_mix_out.sv
// hash mixer and output select
`timescale 1ns/10ps

module hash_mix_out (
  input  hash_pkg::stage_t  stage,
  output logic              hash_valid,
  output hash_pkg::key_t    hash
);

  import hash_pkg::*;
  import hash_cfg_pkg::*;

  // the stage carries the config as a plain field, so view it through
  // the config struct to get at bypass and size by name
  hash_cfg_t stage_cfg;

  assign stage_cfg = stage.cfg;

  // --------------------
  // mixer
  // --------------------

  crc_t mix_a;
  crc_t mix_b;

  // two xor folds of the registered crc against shifted copies of itself
  assign mix_a = stage.crc ^ (stage.crc >> MIX_SHIFT_A);
  assign mix_b = mix_a ^ (mix_a >> MIX_SHIFT_B);

  // --------------------
  // mode decode
  // --------------------

  out_mode_e out_mode;

  // bypass wins over the size field
  always_comb begin
    if (stage_cfg.bypass) begin
      out_mode = OUT_BYPASS;
    end else if (stage_cfg.hash_size == '0) begin
      out_mode = OUT_RAW;
    end else begin
      out_mode = OUT_MIX;
    end
  end

  // --------------------
  // output select
  // --------------------

  // the register block only lets sizes up to 12 through, so the mask
  // never has to cover more than the crc width
  always_comb begin
    hash = '0;
    if (stage.valid) begin
      case (out_mode)
        OUT_BYPASS: hash = stage.key;
        OUT_RAW:    hash[CRC_W-1:0] = stage.key[CRC_W-1:0];
        OUT_MIX: begin
          // keep the low hash_size bits of the mix, zero the rest
          for (int i = 0; i < CRC_W; i++) begin
            hash[i] = mix_b[i] && (i < stage_cfg.hash_size);
          end
        end
        default:    hash = '0;
      endcase
    end
  end

  // bypass results count as valid as well
  assign hash_valid = stage.valid;

endmodule

// File: hdl/hash_pkg.sv
// key hash types and constants
package hash_pkg;

  // --------------------
  // widths
  // --------------------

  // the key width also sets the width of the hash output
  localparam int KEY_W  = 16;
  localparam int CRC_W  = 12;
  localparam int SIZE_W = 6;

  typedef logic [KEY_W-1:0]  key_t;
  typedef logic [CRC_W-1:0]  crc_t;
  typedef logic [SIZE_W-1:0] hash_size_t;

  // largest truncation size that the engine accepts
  localparam int MAX_HASH_SIZE = 12;

  // right-shift amounts of the two xor folds in the mixer
  localparam int MIX_SHIFT_A = 1;
  localparam int MIX_SHIFT_B = 7;

  // --------------------
  // crc equations
  // --------------------

  // crc bit i is the parity of the key bits selected by mask i
  // e.g. bit 0 takes key bits 0, 4, 7, 8, 11, 14 and 15
  localparam key_t CRC_TAPS [0:CRC_W-1] = '{
    16'hC991, 16'h5AB3, 16'hB566, 16'h6ACC,
    16'hD598, 16'h62A1, 16'hC542, 16'h8A84,
    16'hDC99, 16'hB932, 16'h7264, 16'hE4C8
  };

  // output selection, decoded from bypass and the size field
  typedef enum logic [1:0] {
    OUT_RAW    = 2'd0,
    OUT_MIX    = 2'd1,
    OUT_BYPASS = 2'd2
  } out_mode_e;

  // registered content of the input stage
  // cfg is {bypass, hash_size}, the same layout as the config struct
  typedef struct packed {
    logic              valid;
    key_t              key;
    crc_t              crc;
    logic [SIZE_W:0]   cfg;
  } stage_t;

endpackage

// File: hdl/hash_top.sv
// key hash engine top
`timescale 1ns/10ps

module hash_top (
  input  logic                     clk,
  input  logic                     rst_n,
  // register port
  input  logic                     reg_wr,
  input  logic                     reg_rd,
  input  hash_cfg_pkg::cfg_addr_e  reg_addr,
  input  logic [15:0]              reg_wdata,
  output logic [15:0]              reg_rdata,
  // key port
  input  logic                     key_valid,
  input  hash_pkg::key_t           key,
  input  logic                     hold,
  output logic                     hash_valid,
  output hash_pkg::key_t           hash
);

  import hash_pkg::*;
  import hash_cfg_pkg::*;

  // --------------------
  // internal wires
  // --------------------

  // live configuration from the register block
  hash_cfg_t cfg;
  // registered key, crc and config sampled with it
  stage_t    stage;

  hash_cfg_regs i_hash_cfg_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .cfg       (cfg)
  );

  // the only register on the key path, giving one edge of latency
  hash_crc_stage i_hash_crc_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .key_valid (key_valid),
    .key       (key),
    .hold      (hold),
    .cfg       (cfg),
    .stage     (stage)
  );

  hash_mix_out i_hash_mix_out (
    .stage      (stage),
    .hash_valid (hash_valid),
    .hash       (hash)
  );

endmodule

// File: sim/hash_checker.sv
// hash output assertions
`timescale 1ns/10ps

module hash_checker (
  input logic           clk,
  input logic           rst_n,
  input logic           hold,
  input logic           hash_valid,
  input hash_pkg::key_t hash
);

  // number of failed assertions, summed into the testbench verdict
  int fail_count = 0;

  // --------------------
  // reset
  // --------------------

  // nothing may be flagged valid while reset is applied
  reset_quiet: assert property (@(posedge clk) !rst_n |-> !hash_valid)
    else begin
      $error("hash_valid high during reset");
      fail_count++;
    end

  // --------------------
  // hold
  // --------------------

  // the stage keeps its item, so the result cannot move
  // as long as hold was high at this edge and the one before
  hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (hold && $past(hold)) |-> $stable(hash))
    else begin
      $error("hash changed while hold stayed high");
      fail_count++;
    end

  // --------------------
  // output rules
  // --------------------

  // an empty stage drives a zero result
  idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
    !hash_valid |-> (hash == '0))
    else begin
      $error("hash not zero while hash_valid is low");
      fail_count++;
    end

endmodule

// File: sim/hash_tb.sv
// key hash engine testbench
`timescale 1ns/10ps

module hash_tb;

  import hash_pkg::*;
  import hash_cfg_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 4;
  localparam int RAND_KEYS    = 200;

  // --------------------
  // stimulus table
  // --------------------

  typedef enum logic [2:0] {
    OP_IDLE, OP_WRITE, OP_READ, OP_KEY, OP_HOLD_KEY, OP_WRITE_KEY
  } op_e;

  // what the hash outputs show one edge after the step
  typedef enum logic [1:0] {
    CLS_IDLE, CLS_HASH, CLS_HELD
  } cls_e;

  typedef struct packed {
    op_e         op;
    cfg_addr_e   addr;
    logic [15:0] data;
    key_t        key;
    cls_e        cls;
  } step_t;

  step_t steps [$];

  // own copy of the crc equations, one key mask per crc bit
  localparam logic [15:0] MODEL_TAPS [0:11] = '{
    16'hC991, 16'h5AB3, 16'hB566, 16'h6ACC,
    16'hD598, 16'h62A1, 16'hC542, 16'h8A84,
    16'hDC99, 16'hB932, 16'h7264, 16'hE4C8
  };

  logic        clk;
  logic        rst_n;
  logic        reg_wr;
  logic        reg_rd;
  cfg_addr_e   reg_addr;
  logic [15:0] reg_wdata;
  logic [15:0] reg_rdata;
  logic        key_valid;
  key_t        key;
  logic        hold;
  logic        hash_valid;
  key_t        hash;

  // shadow of the register block and the expected outputs
  logic        sh_bypass;
  logic [5:0]  sh_size;
  logic        sh_bad_size;
  logic        exp_valid;
  key_t        exp_hash;
  int          errors;
  int          checks;
  integer      seed = 58948;

  hash_top i_hash_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .reg_wr     (reg_wr),
    .reg_rd     (reg_rd),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata),
    .key_valid  (key_valid),
    .key        (key),
    .hold       (hold),
    .hash_valid (hash_valid),
    .hash       (hash)
  );

  bind hash_top hash_checker i_hash_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .hold       (hold),
    .hash_valid (hash_valid),
    .hash       (hash)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------
  // reference model
  // --------------------

  // crc, two xor folds, then bypass, raw or truncated mix
  function automatic key_t model_hash(key_t k, logic byp, logic [5:0] size);
    logic [11:0] crc;
    logic [11:0] fold_a;
    logic [11:0] fold_b;
    logic [12:0] mask;
    for (int i = 0; i < 12; i++) begin
      crc[i] = ^(k & MODEL_TAPS[i]);
    end
    fold_a = crc ^ (crc >> 1);
    fold_b = fold_a ^ (fold_a >> 7);
    mask   = (13'h1 << size) - 13'h1;
    if (byp) begin
      return k;
    end else if (size == 6'd0) begin
      return {4'h0, k[11:0]};
    end
    return {4'h0, fold_b & mask[11:0]};
  endfunction

  // sizes above 12 are refused and leave the sticky flag set
  task automatic model_write(cfg_addr_e addr, logic [15:0] data);
    case (addr)
      CFG_CTRL: sh_bypass = data[0];
      CFG_SIZE: begin
        if (data > 16'd12) begin
          sh_bad_size = 1'b1;
        end else begin
          sh_size = data[5:0];
        end
      end
      CFG_STATUS: sh_bad_size = 1'b0;
      default: sh_bad_size = sh_bad_size;
    endcase
  endtask

  function automatic logic [15:0] expected_rdata(cfg_addr_e addr);
    case (addr)
      CFG_CTRL:   return {15'h0, sh_bypass};
      CFG_SIZE:   return {10'h0, sh_size};
      CFG_STATUS: return {15'h0, sh_bad_size};
      default:    return 16'h0;
    endcase
  endfunction

  // --------------------
  // checks and steps
  // --------------------

  task automatic check(string name, logic [15:0] expected, logic [15:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic add_step(op_e op, cfg_addr_e addr, logic [15:0] data, key_t k, cls_e cls);
    steps.push_back('{op: op, addr: addr, data: data, key: k, cls: cls});
  endtask

  // one clock per step, entered and left on a falling edge
  task automatic run_step(step_t s);
    logic next_valid;
    key_t next_hash;
    reg_wr     = (s.op == OP_WRITE) || (s.op == OP_WRITE_KEY);
    reg_rd     = (s.op == OP_READ);
    reg_addr   = s.addr;
    reg_wdata  = s.data;
    key_valid  = (s.op == OP_KEY) || (s.op == OP_HOLD_KEY) || (s.op == OP_WRITE_KEY);
    key        = s.key;
    hold       = (s.op == OP_HOLD_KEY);
    next_valid = exp_valid;
    next_hash  = exp_hash;
    // a key uses the config in force before a write in the same edge
    if (s.cls == CLS_HASH) begin
      next_valid = 1'b1;
      next_hash  = model_hash(s.key, sh_bypass, sh_size);
    end else if (s.cls == CLS_IDLE) begin
      next_valid = 1'b0;
      next_hash  = '0;
    end
    if (s.op == OP_READ) begin
      #(CLK_PERIOD / 5);
      check("reg_rdata", expected_rdata(s.addr), reg_rdata);
    end
    @(posedge clk);
    if ((s.op == OP_WRITE) || (s.op == OP_WRITE_KEY)) begin
      model_write(s.addr, s.data);
    end
    exp_valid = next_valid;
    exp_hash  = next_hash;
    @(negedge clk);
    check("hash_valid", {15'h0, exp_valid}, {15'h0, hash_valid});
    check("hash", exp_hash, hash);
  endtask

  task automatic build_table();
    // register contents straight out of reset
    add_step(OP_READ, CFG_CTRL, 16'h0, 16'h0, CLS_IDLE);
    add_step(OP_READ, CFG_SIZE, 16'h0, 16'h0, CLS_IDLE);
    add_step(OP_READ, CFG_STATUS, 16'h0, 16'h0, CLS_IDLE);
    // every legal mix size, each key followed by an empty cycle
    for (int sz = 1; sz <= 12; sz++) begin
      add_step(OP_WRITE, CFG_SIZE, 16'(sz), 16'h0, CLS_IDLE);
      add_step(OP_KEY, CFG_CTRL, 16'h0, 16'hA5C3 ^ 16'(sz * 16'h0F1D), CLS_HASH);
      add_step(OP_IDLE, CFG_CTRL, 16'h0, 16'h0, CLS_IDLE);
    end
    // raw key bits at size 0, then the full key in bypass
    add_step(OP_WRITE, CFG_SIZE, 16'd0, 16'h0, CLS_IDLE);
    add_step(OP_KEY, CFG_CTRL, 16'h0, 16'hBEEF, CLS_HASH);
    add_step(OP_WRITE, CFG_CTRL, 16'h1, 16'h0, CLS_IDLE);
    add_step(OP_READ, CFG_CTRL, 16'h0, 16'h0, CLS_IDLE);
    add_step(OP_KEY, CFG_CTRL, 16'h0, 16'hF00D, CLS_HASH);
    add_step(OP_WRITE, CFG_CTRL, 16'h0, 16'h0, CLS_IDLE);
    // keys offered under hold are lost and the result stays put
    add_step(OP_WRITE, CFG_SIZE, 16'd9, 16'h0, CLS_IDLE);
    add_step(OP_KEY, CFG_CTRL, 16'h0, 16'h3C5A, CLS_HASH);
    add_step(OP_HOLD_KEY, CFG_CTRL, 16'h0, 16'h1111, CLS_HELD);
    add_step(OP_HOLD_KEY, CFG_CTRL, 16'h0, 16'h2222, CLS_HELD);
    add_step(OP_KEY, CFG_CTRL, 16'h0, 16'h4444, CLS_HASH);
    // reserved sizes are refused, 0x40 must not alias onto size 0
    add_step(OP_WRITE, CFG_SIZE, 16'd13, 16'h0, CLS_IDLE);
    add_step(OP_READ, CFG_SIZE, 16'h0, 16'h0, CLS_IDLE);
    add_step(OP_READ, CFG_STATUS, 16'h0, 16'h0, CLS_IDLE);
    add_step(OP_KEY, CFG_CTRL, 16'h0, 16'h9A0F, CLS_HASH);
    add_step(OP_WRITE, CFG_SIZE, 16'h0040, 16'h0, CLS_IDLE);
    add_step(OP_READ, CFG_SIZE, 16'h0, 16'h0, CLS_IDLE);
    add_step(OP_WRITE, CFG_STATUS, 16'h0, 16'h0, CLS_IDLE);
    add_step(OP_READ, CFG_STATUS, 16'h0, 16'h0, CLS_IDLE);
    // a write in the same edge as a key only reaches the next key
    add_step(OP_WRITE_KEY, CFG_SIZE, 16'd3, 16'h7E81, CLS_HASH);
    add_step(OP_KEY, CFG_CTRL, 16'h0, 16'h7E81, CLS_HASH);
    add_step(OP_WRITE_KEY, CFG_CTRL, 16'h1, 16'h5A5A, CLS_HASH);
    add_step(OP_KEY, CFG_CTRL, 16'h0, 16'h5A5A, CLS_HASH);
    add_step(OP_WRITE, CFG_CTRL, 16'h0, 16'h0, CLS_IDLE);
    add_step(OP_IDLE, CFG_CTRL, 16'h0, 16'h0, CLS_IDLE);
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin : main
    step_t rnd_step;
    int    assert_fails;
    reg_wr      = 1'b0;
    reg_rd      = 1'b0;
    reg_addr    = CFG_CTRL;
    reg_wdata   = 16'h0;
    key_valid   = 1'b0;
    key         = 16'h0;
    hold        = 1'b0;
    rst_n       = 1'b0;
    sh_bypass   = 1'b0;
    sh_size     = 6'd12;
    sh_bad_size = 1'b0;
    exp_valid   = 1'b0;
    exp_hash    = '0;
    errors      = 0;
    checks      = 0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check("hash_valid", 16'h0, {15'h0, hash_valid});
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    // back-to-back random keys, each with a new size written alongside
    for (int n = 0; n < RAND_KEYS; n++) begin
      rnd_step.op   = OP_WRITE_KEY;
      rnd_step.addr = CFG_SIZE;
      rnd_step.data = 16'($unsigned($random(seed)) % 13);
      rnd_step.key  = 16'($random(seed));
      rnd_step.cls  = CLS_HASH;
      run_step(rnd_step);
    end
    // the bound assertions count their own failures
    assert_fails = i_hash_top.i_hash_checker.fail_count;
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if ((errors == 0) && (assert_fails == 0)) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // limit is the table plus the random keys plus a margin for reset
  initial begin : watchdog
    longint limit;
    #1;
    limit = longint'(steps.size() + RAND_KEYS + 20) * CLK_PERIOD;
    #(limit);
    $display("timeout: the test did not finish within %0d ns", limit);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
